//--- store_unit_top.f
+incdir+design
+incdir+bench
design/sq_types_pkg.sv
design/mem_bus_pkg.sv
design/store_queue.sv
design/store_drain.sv
design/store_unit_top.sv
bench/store_unit_tb.sv

//--- bench/store_unit_table.svh
// =========================================================================
// Store unit stimulus table
// Dispatch groups, retire counts and mispredicts with expected alloc_idxs
// =========================================================================

`ifndef STORE_UNIT_TABLE_SVH
`define STORE_UNIT_TABLE_SVH

// Test that runs with long APB wait states
localparam int SLOW_TEST = 6;

// Column order is test, mask, addr0, data0, size0, addr1, data1, size1,
// retire, mispredict, expected alloc_idxs[0] and alloc_idxs[1]
task automatic fill_table();
    // Test 1 wraps indices over one and two store groups
    add_row(1, 2'b11, 'h1000, 'h11110001, SZ_WORD, 'h1004, 'h11110002, SZ_WORD, 0, 0, 0, 1);
    add_row(1, 2'b01, 'h1008, 'h11110003, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 2, 3);
    add_row(1, 2'b11, 'h100C, 'h11110004, SZ_WORD, 'h1010, 'h11110005, SZ_WORD, 1, 0, 3, 4);
    add_row(1, 2'b11, 'h1014, 'h11110006, SZ_WORD, 'h1018, 'h11110007, SZ_WORD, 2, 0, 5, 6);
    add_row(1, 2'b01, 'h101C, 'h11110008, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 7, 0);
    add_row(1, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 1, 0, 0, 1);
    // Test 2 keeps program order on APB
    add_row(2, 2'b11, 'h2040, 'h22220001, SZ_WORD, 'h2001, 'h22220002, SZ_WORD, 0, 0, 0, 1);
    add_row(2, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 2, 3);
    // Test 3 covers byte, half and word stores at each offset
    add_row(3, 2'b11, 'h3000, 'h000000A5, SZ_BYTE, 'h3001, 'h0000005A, SZ_BYTE, 0, 0, 2, 3);
    add_row(3, 2'b11, 'h3002, 'h000000C3, SZ_BYTE, 'h3003, 'h0000003C, SZ_BYTE, 2, 0, 4, 5);
    add_row(3, 2'b11, 'h3005, 'h0000BEEF, SZ_HALF, 'h3006, 'h0000CAFE, SZ_HALF, 2, 0, 6, 7);
    add_row(3, 2'b11, 'h3007, 'h00001234, SZ_HALF, 'h300A, 'hDEADBEEF, SZ_WORD, 2, 0, 0, 1);
    add_row(3, 2'b01, 'h3013, 'h87654321, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 2, 3);
    add_row(3, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 1, 0, 3, 4);
    // Test 4 mispredict drops uncommitted stores and that cycle's dispatch
    add_row(4, 2'b11, 'h4000, 'h44440001, SZ_WORD, 'h4004, 'h44440002, SZ_WORD, 0, 0, 3, 4);
    add_row(4, 2'b11, 'h4008, 'h44440003, SZ_WORD, 'h400C, 'h44440004, SZ_WORD, 1, 0, 5, 6);
    add_row(4, 2'b11, 'h4010, 'h44440005, SZ_WORD, 'h4014, 'h44440006, SZ_WORD, 0, 1, 7, 0);
    add_row(4, 2'b11, 'h4018, 'h44440007, SZ_WORD, 'h401C, 'h44440008, SZ_WORD, 0, 0, 4, 5);
    add_row(4, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 6, 7);
    // Test 5 retires and mispredicts in one cycle
    add_row(5, 2'b11, 'h5000, 'h55550001, SZ_WORD, 'h5004, 'h55550002, SZ_BYTE, 0, 0, 6, 7);
    add_row(5, 2'b01, 'h5008, 'h55550003, SZ_WORD, 'h0, 'h0, SZ_WORD, 0, 0, 0, 1);
    add_row(5, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 1, 1, 2);
    add_row(5, 2'b01, 'h500C, 'h55550004, SZ_HALF, 'h0, 'h0, SZ_WORD, 0, 0, 0, 1);
    add_row(5, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 1, 0, 1, 2);
    // Test 6 back-pressure fills the queue before anything retires
    add_row(6, 2'b11, 'h6000, 'h66660001, SZ_WORD, 'h6004, 'h66660002, SZ_WORD, 0, 0, 1, 2);
    add_row(6, 2'b11, 'h6008, 'h66660003, SZ_WORD, 'h600C, 'h66660004, SZ_WORD, 0, 0, 3, 4);
    add_row(6, 2'b11, 'h6010, 'h66660005, SZ_WORD, 'h6014, 'h66660006, SZ_WORD, 0, 0, 5, 6);
    add_row(6, 2'b11, 'h6018, 'h66660007, SZ_WORD, 'h601C, 'h66660008, SZ_WORD, 0, 0, 7, 0);
    add_row(6, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 1, 2);
    add_row(6, 2'b01, 'h6020, 'h66660009, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 1, 2);
    add_row(6, 2'b11, 'h6024, 'h6666000A, SZ_WORD, 'h6028, 'h6666000B, SZ_WORD, 2, 0, 2, 3);
    add_row(6, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 4, 5);
    add_row(6, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 2, 0, 4, 5);
    add_row(6, 2'b00, 'h0, 'h0, SZ_WORD, 'h0, 'h0, SZ_WORD, 1, 0, 4, 5);
endtask

`endif

//--- bench/store_unit_tb.sv
// =========================================================================
// Store unit testbench
// Table driven dispatch, retire and mispredict with an APB memory model,
// reference store queues and per-test report
// =========================================================================

`timescale 1ns/1ns
`include "sq_defs.svh"

module store_unit_tb
    import sq_types_pkg::*;
    import mem_bus_pkg::*;
;
    typedef logic [$clog2(`LSQ_SZ+1)-1:0] cnt_t;

    typedef struct packed {
        logic [3:0]  tst;
        logic [1:0]  mask;
        logic [31:0] a0;
        logic [31:0] d0;
        sq_size_e    s0;
        logic [31:0] a1;
        logic [31:0] d1;
        sq_size_e    s1;
        logic [1:0]  ret;
        logic        misp;
        sq_idx_t     e0;
        sq_idx_t     e1;
    } row_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        sq_size_e    size;
    } store_t;

    logic                               clock;
    logic                               rst_n;
    logic      [`N-1:0]                 dispatch_valid;
    logic      [`N-1:0][`SQ_ADDR_W-1:0] dispatch_addr;
    logic      [`N-1:0][`SQ_DATA_W-1:0] dispatch_data;
    sq_size_e  [`N-1:0]                 dispatch_size;
    sq_idx_t   [`N-1:0]                 alloc_idxs;
    cnt_t                               free_slots;
    logic      [$clog2(`N+1)-1:0]       retire_count;
    logic                               mispredict;
    logic      [`SQ_ADDR_W-1:0]         paddr;
    logic      [`SQ_DATA_W-1:0]         pwdata;
    strb_t                              pstrb;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic                               pready;

    // Stimulus rows and the reference store queues
    row_t   table_q[$];
    store_t unc_q[$];
    store_t committed_q[$];
    int     errs;
    int     test_errs;
    int     max_wait;
    int     wait_cnt;
    int     draw;
    integer seed;
    cnt_t   min_free;
    // APB state seen at the previous falling edge
    logic   prev_sel;
    logic   prev_en;
    logic   prev_rdy;

    store_unit_top DUT (.*);

    always #50 clock = ~clock;

    task automatic add_row(int tst, logic [1:0] mask, logic [31:0] a0, logic [31:0] d0,
                           sq_size_e s0, logic [31:0] a1, logic [31:0] d1, sq_size_e s1,
                           int ret, int misp, int e0, int e1);
        table_q.push_back({4'(tst), mask, a0, d0, s0, a1, d1, s1, 2'(ret), 1'(misp),
                           sq_idx_t'(e0), sq_idx_t'(e1)});
    endtask

    `include "store_unit_table.svh"

    // =====================================================================
    // Compare tasks
    // =====================================================================
    task automatic check_idx(string sig, sq_idx_t exp, sq_idx_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%0d act=%0d", $time, sig, exp, act);
            errs++;
        end
    endtask

    task automatic check_strb(string sig, strb_t exp, strb_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%b act=%b", $time, sig, exp, act);
            errs++;
        end
    endtask

    task automatic check_count(string sig, cnt_t exp, cnt_t act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%0d act=%0d", $time, sig, exp, act);
            errs++;
        end
    endtask

    task automatic check_word(string sig, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%h act=%h", $time, sig, exp, act);
            errs++;
        end
    endtask

    // Strobe and lane data from size and low address bits
    function automatic strb_t lane_strobe(store_t st);
        case (st.size)
            SZ_BYTE: return strb_t'(1 << st.addr[1:0]);
            SZ_HALF: return st.addr[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_word(store_t st);
        case (st.size)
            SZ_BYTE: return {4{st.data[7:0]}};
            SZ_HALF: return {2{st.data[15:0]}};
            default: return st.data;
        endcase
    endfunction

    task automatic drive_idle();
        dispatch_valid <= '0;
        retire_count   <= '0;
        mispredict     <= 1'b0;
    endtask

    // =====================================================================
    // APB memory model with random wait states per transfer
    // =====================================================================
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pready   <= 1'b0;
            wait_cnt <= 0;
        end else if (psel && !penable) begin
            // Wait states drawn in the setup cycle
            draw     = $unsigned($random(seed)) % (max_wait + 1);
            wait_cnt <= draw;
            pready   <= (draw == 0);
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
            end else begin
                if (wait_cnt == 1) begin
                    pready <= 1'b1;
                end
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // APB protocol and write data monitor
    always @(negedge clock) begin
        if (rst_n) begin
            if (free_slots < min_free) begin
                min_free = free_slots;
            end
            if (pwrite !== psel) begin
                $display("%0t: pwrite does not follow psel", $time);
                errs++;
            end
            // Access follows a setup cycle or a held access only
            if (penable && !(psel && prev_sel && !(prev_en && prev_rdy))) begin
                $display("%0t: access phase without a setup cycle", $time);
                errs++;
            end
            if (prev_sel && !prev_en && !(psel && penable)) begin
                $display("%0t: setup cycle not followed by an access phase", $time);
                errs++;
            end
            if (prev_sel && prev_en && prev_rdy && psel) begin
                $display("%0t: no idle cycle after a completed transfer", $time);
                errs++;
            end
            if (prev_sel && prev_en && !prev_rdy && !(psel && penable)) begin
                $display("%0t: access phase dropped before pready", $time);
                errs++;
            end
            // Completing transfer must carry the oldest committed store
            if (psel && penable && pready) begin
                if (committed_q.size() == 0) begin
                    $display("%0t: APB write with no committed store pending", $time);
                    errs++;
                end else begin
                    check_word("paddr", committed_q[0].addr & ~32'h3, paddr);
                    check_strb("pstrb", lane_strobe(committed_q[0]), pstrb);
                    check_word("pwdata", lane_word(committed_q[0]), pwdata);
                    void'(committed_q.pop_front());
                end
            end
            prev_sel = psel;
            prev_en  = penable;
            prev_rdy = pready;
        end
    end

    // Watchdog sized from the table length
    initial begin
        drain_state_e st;
        wait (table_q.size() != 0);
        #(table_q.size() * `LSQ_SZ * 6 * 100);
        st = DUT.u_store_drain.state;
        $display("Watchdog expired, drain hung in %s with %0d stores unwritten",
                 st.name(), committed_q.size());
        $display("tests failed");
        $finish;
    end

    // =====================================================================
    // Table loop
    // =====================================================================
    initial begin
        row_t r;
        int   need;
        int   pend;
        int   tests;
        clock = 1'b0;
        rst_n = 1'b0;
        pready = 1'b0;
        dispatch_valid = '0;
        dispatch_addr = '0;
        dispatch_data = '0;
        dispatch_size = {`N{SZ_WORD}};
        retire_count = '0;
        mispredict = 1'b0;
        seed = 32'hc5d6b10c;
        errs = 0;
        test_errs = 0;
        tests = 0;
        pend = 0;
        max_wait = 3;
        min_free = `LSQ_SZ;
        prev_sel = 1'b0;
        prev_en = 1'b0;
        prev_rdy = 1'b0;
        fill_table();
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_count("free_slots", `LSQ_SZ, free_slots);
        for (int k = 0; k < table_q.size(); k++) begin
            r = table_q[k];
            max_wait = (r.tst == SLOW_TEST) ? 12 : 3;
            need = r.mask[0] + r.mask[1];
            // Never offer more stores than the queue has room for
            if (!r.misp) begin
                while (free_slots < cnt_t'(need + pend)) begin
                    @(posedge clock);
                    drive_idle();
                    pend = 0;
                    @(negedge clock);
                end
            end
            @(posedge clock);
            dispatch_valid   <= r.mask;
            dispatch_addr[0] <= r.a0;
            dispatch_data[0] <= r.d0;
            dispatch_size[0] <= r.s0;
            dispatch_addr[1] <= r.a1;
            dispatch_data[1] <= r.d1;
            dispatch_size[1] <= r.s1;
            retire_count     <= r.ret;
            mispredict       <= r.misp;
            @(negedge clock);
            check_idx("alloc_idxs[0]", r.e0, alloc_idxs[0]);
            check_idx("alloc_idxs[1]", r.e1, alloc_idxs[1]);
            // Reference model retires first, then flushes or appends
            for (int i = 0; i < r.ret; i++) begin
                committed_q.push_back(unc_q.pop_front());
            end
            if (r.misp) begin
                unc_q.delete();
            end else begin
                if (r.mask[0]) begin
                    unc_q.push_back({r.a0, r.d0, r.s0});
                end
                if (r.mask[1]) begin
                    unc_q.push_back({r.a1, r.d1, r.s1});
                end
            end
            // Free count lags a dispatch by one cycle
            pend = r.misp ? 0 : need;
            // Let the drain go quiet after the last row of a test
            if (k == table_q.size() - 1 || table_q[k+1].tst != r.tst) begin
                @(posedge clock);
                drive_idle();
                pend = 0;
                @(negedge clock);
                while (committed_q.size() != 0 || psel) begin
                    @(negedge clock);
                end
                check_count("free_slots", cnt_t'(`LSQ_SZ - unc_q.size()), free_slots);
                if (r.tst == SLOW_TEST) begin
                    check_count("free_slots minimum", '0, min_free);
                end
                $display("test %0d done, %0d errors", r.tst, errs - test_errs);
                test_errs = errs;
                tests++;
                min_free = `LSQ_SZ;
            end
        end
        $display("%0d tests run, %0d errors", tests, errs);
        if (errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- design/store_unit_top.sv
// =========================================================================
// Store unit top
// Store queue and its APB drain engine, with dispatch, retire, mispredict
// and APB write ports brought out
// =========================================================================

`timescale 1ns/1ns
`include "sq_defs.svh"

module store_unit_top
    import sq_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                               clock,
    input  logic                               rst_n,

    // Dispatch
    input  logic      [`N-1:0]                 dispatch_valid,
    input  logic      [`N-1:0][`SQ_ADDR_W-1:0] dispatch_addr,
    input  logic      [`N-1:0][`SQ_DATA_W-1:0] dispatch_data,
    input  sq_size_e  [`N-1:0]                 dispatch_size,
    output sq_idx_t   [`N-1:0]                 alloc_idxs,
    output logic      [$clog2(`LSQ_SZ+1)-1:0]  free_slots,

    // Retire and flush
    input  logic      [$clog2(`N+1)-1:0]       retire_count,
    input  logic                               mispredict,

    // APB write master
    output logic      [`SQ_ADDR_W-1:0]         paddr,
    output logic      [`SQ_DATA_W-1:0]         pwdata,
    output strb_t                              pstrb,
    output logic                               psel,
    output logic                               penable,
    output logic                               pwrite,
    input  logic                               pready
);

    // Queue head to drain
    logic                  head_valid;
    logic [`SQ_ADDR_W-1:0] head_addr;
    logic [`SQ_DATA_W-1:0] head_data;
    sq_size_e              head_size;
    logic                  head_pop;

    store_queue u_store_queue (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_addr  (dispatch_addr),
        .dispatch_data  (dispatch_data),
        .dispatch_size  (dispatch_size),
        .alloc_idxs     (alloc_idxs),
        .free_slots     (free_slots),
        .retire_count   (retire_count),
        .mispredict     (mispredict),
        .head_valid     (head_valid),
        .head_addr      (head_addr),
        .head_data      (head_data),
        .head_size      (head_size),
        .head_pop       (head_pop)
    );

    store_drain u_store_drain (
        .clock      (clock),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_size  (head_size),
        .head_pop   (head_pop),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pready     (pready)
    );

endmodule

//--- design/store_drain.sv
// =========================================================================
// Store drain engine
// APB write master that takes committed stores from the queue head one at
// a time, places data in the addressed byte lanes with matching strobes
// and pops the head when the transfer completes
// =========================================================================

`timescale 1ns/1ns
`include "sq_defs.svh"

module store_drain
    import sq_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,

    // Queue head
    input  logic                   head_valid,
    input  logic [`SQ_ADDR_W-1:0]  head_addr,
    input  logic [`SQ_DATA_W-1:0]  head_data,
    input  sq_size_e               head_size,
    output logic                   head_pop,

    // =====================================================================
    // APB master
    // =====================================================================
    output logic [`SQ_ADDR_W-1:0]  paddr,
    output logic [`SQ_DATA_W-1:0]  pwdata,
    output strb_t                  pstrb,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    input  logic                   pready
);

    drain_state_e state;
    drain_state_e state_next;

    // Byte offset of the head store within its word
    logic [1:0] offset;

    // Lane placed data and strobe for the head store
    logic [`SQ_DATA_W-1:0] lane_data;
    strb_t                 lane_strb;

    // Transfer payload, held for the whole transfer
    logic [`SQ_ADDR_W-1:0] addr_q;
    logic [`SQ_DATA_W-1:0] data_q;
    strb_t                 strb_q;

    // Access phase meets pready
    logic xfer_done;

    assign offset = head_addr[1:0];

    // =====================================================================
    // Strobe and lane placement
    // =====================================================================
    always_comb begin
        case (head_size)
            SZ_BYTE: begin
                // One lane, data copied to every byte
                lane_strb = strb_t'(1) << offset;
                lane_data = {(`SQ_DATA_W/8){head_data[7:0]}};
            end
            SZ_HALF: begin
                // Upper or lower half by bit 1 of the offset
                lane_strb = offset[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
                lane_data = {(`SQ_DATA_W/16){head_data[15:0]}};
            end
            default: begin
                // Word, and the reserved code treated as word
                lane_strb = '1;
                lane_data = head_data;
            end
        endcase
    end

    // =====================================================================
    // Drain FSM
    // =====================================================================
    assign xfer_done = (state == DR_ACCESS) && pready;

    always_comb begin
        state_next = state;
        case (state)
            DR_IDLE: begin
                if (head_valid) begin
                    state_next = DR_SETUP;
                end
            end
            DR_SETUP: begin
                state_next = DR_ACCESS;
            end
            DR_ACCESS: begin
                // Back to idle so the popped head_valid is seen first
                if (pready) begin
                    state_next = DR_IDLE;
                end
            end
            default: begin
                state_next = DR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= DR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Capture head store on entry to setup
    always_ff @(posedge clock) begin
        if (state == DR_IDLE && head_valid) begin
            addr_q <= {head_addr[`SQ_ADDR_W-1:2], 2'b00};
            data_q <= lane_data;
            strb_q <= lane_strb;
        end
    end

    // =====================================================================
    // Outputs
    // =====================================================================
    assign psel     = (state != DR_IDLE);
    assign penable  = (state == DR_ACCESS);
    // Write only master
    assign pwrite   = psel;
    assign paddr    = addr_q;
    assign pwdata   = data_q;
    assign pstrb    = strb_q;

    // Head advances on the completing edge
    assign head_pop = xfer_done;

endmodule

//--- design/store_queue.sv
// =========================================================================
// Store queue
// Circular buffer of stores in program order. Takes up to N stores per
// cycle at the tail, commits by retire count, rewinds the tail on a
// mispredict and frees the head when the drain pops it
// =========================================================================

`timescale 1ns/1ns
`include "sq_defs.svh"

module store_queue
    import sq_types_pkg::*;
(
    input  logic                               clock,
    input  logic                               rst_n,

    // =====================================================================
    // Dispatch
    // =====================================================================
    input  logic      [`N-1:0]                 dispatch_valid,
    input  logic      [`N-1:0][`SQ_ADDR_W-1:0] dispatch_addr,
    input  logic      [`N-1:0][`SQ_DATA_W-1:0] dispatch_data,
    input  sq_size_e  [`N-1:0]                 dispatch_size,
    output sq_idx_t   [`N-1:0]                 alloc_idxs,
    output logic      [$clog2(`LSQ_SZ+1)-1:0]  free_slots,

    // =====================================================================
    // Retire and flush
    // =====================================================================
    input  logic      [$clog2(`N+1)-1:0]       retire_count,
    input  logic                               mispredict,

    // =====================================================================
    // Head entry to drain
    // =====================================================================
    output logic                               head_valid,
    output logic      [`SQ_ADDR_W-1:0]         head_addr,
    output logic      [`SQ_DATA_W-1:0]         head_data,
    output sq_size_e                           head_size,
    input  logic                               head_pop
);

    // Count width, holds 0 to depth inclusive
    localparam int CNT_W = $clog2(`LSQ_SZ+1);

    // Store payload, no reset
    logic     [`SQ_ADDR_W-1:0] addr_mem [`LSQ_SZ];
    logic     [`SQ_DATA_W-1:0] data_mem [`LSQ_SZ];
    sq_size_e                  size_mem [`LSQ_SZ];

    // Oldest entry, first uncommitted entry, next free entry
    sq_idx_t head_ptr;
    sq_idx_t commit_ptr;
    sq_idx_t tail_ptr;
    sq_idx_t commit_ptr_next;
    sq_idx_t tail_ptr_next;

    // Committed but not yet drained, and free slots
    logic [CNT_W-1:0] committed_cnt;
    logic [CNT_W-1:0] committed_next;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] free_next;

    // Stores offered this cycle
    logic [CNT_W-1:0] disp_cnt;

    // =====================================================================
    // Dispatch count and allocation
    // =====================================================================

    // Valid lanes are contiguous from lane 0, so a popcount is the count
    always_comb begin
        disp_cnt = '0;
        for (int i = 0; i < `N; i++) begin
            if (dispatch_valid[i]) begin
                disp_cnt = disp_cnt + CNT_W'(1);
            end
        end
    end

    // Lane i lands at tail+i, wrap is implicit in the index width
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            alloc_idxs[i] = tail_ptr + sq_idx_t'(i);
        end
    end

    // =====================================================================
    // Pointer and count update
    // =====================================================================
    always_comb begin
        // Retire applies first, also in a mispredict cycle
        commit_ptr_next = commit_ptr + sq_idx_t'(retire_count);
        committed_next  = committed_cnt + CNT_W'(retire_count) - CNT_W'(head_pop);

        if (mispredict) begin
            // Drop every uncommitted store, dispatch this cycle is lost too
            tail_ptr_next = commit_ptr_next;
            free_next     = CNT_W'(`LSQ_SZ) - committed_next;
        end else begin
            tail_ptr_next = tail_ptr + sq_idx_t'(disp_cnt);
            // Dispatch takes slots, pop gives one back
            free_next     = free_cnt - disp_cnt + CNT_W'(head_pop);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr      <= '0;
            commit_ptr    <= '0;
            tail_ptr      <= '0;
            committed_cnt <= '0;
            free_cnt      <= CNT_W'(`LSQ_SZ);
            head_valid    <= 1'b0;
        end else begin
            if (head_pop) begin
                head_ptr <= head_ptr + sq_idx_t'(1);
            end
            commit_ptr    <= commit_ptr_next;
            tail_ptr      <= tail_ptr_next;
            committed_cnt <= committed_next;
            free_cnt      <= free_next;
            // Head drainable once something is committed
            head_valid    <= (committed_next != '0);
        end
    end

    // =====================================================================
    // Payload write
    // =====================================================================
    always_ff @(posedge clock) begin
        if (!mispredict) begin
            for (int i = 0; i < `N; i++) begin
                if (dispatch_valid[i]) begin
                    addr_mem[alloc_idxs[i]] <= dispatch_addr[i];
                    data_mem[alloc_idxs[i]] <= dispatch_data[i];
                    size_mem[alloc_idxs[i]] <= dispatch_size[i];
                end
            end
        end
    end

    // =====================================================================
    // Outputs
    // =====================================================================

    // Head entry straight from storage flops at the registered head
    assign head_addr  = addr_mem[head_ptr];
    assign head_data  = data_mem[head_ptr];
    assign head_size  = size_mem[head_ptr];

    assign free_slots = free_cnt;

endmodule

//--- design/mem_bus_pkg.sv
// =========================================================================
// Memory bus types
// APB drain FSM states and the byte strobe type of the write bus
// =========================================================================

`include "sq_defs.svh"

package mem_bus_pkg;

    // Drain FSM
    // Idle waits for a committed head, setup drives psel alone,
    // access adds penable and holds until pready
    typedef enum logic [1:0] {
        DR_IDLE   = 2'b00,
        DR_SETUP  = 2'b01,
        DR_ACCESS = 2'b10
    } drain_state_e;

    // One strobe bit per data byte lane
    typedef logic [`SQ_DATA_W/8-1:0] strb_t;

endpackage

//--- design/sq_types_pkg.sv
// =========================================================================
// Store queue types
// Size opcode carried with every store and the queue slot index type
// =========================================================================

`include "sq_defs.svh"

package sq_types_pkg;

    // Slot index width, log2 of queue depth
    localparam int SQ_IDX_W = $clog2(`LSQ_SZ);

    // =====================================================================
    // Store size opcode
    // =====================================================================

    // Access size of a store as dispatched
    // Reserved code is drained as a full word
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10,
        SZ_RSVD = 2'b11
    } sq_size_e;

    // =====================================================================
    // Queue slot index
    // =====================================================================

    // Wraps modulo depth by plain overflow
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;

endpackage

//--- design/sq_defs.svh
// =========================================================================
// Store unit global sizes
// Dispatch width, store queue depth and the address and data widths
// shared by the queue, the drain engine and the top level
// =========================================================================

`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// =========================================================================
// Dispatch side
// =========================================================================

// Stores accepted per cycle from dispatch
`define N 2

// Store queue entries, power of two so indices wrap for free
`define LSQ_SZ 8

// =========================================================================
// Memory side
// =========================================================================

// Byte address width of a store
`define SQ_ADDR_W 32

// Store data width, also the APB data bus width
`define SQ_DATA_W 32

`endif
